// ==== hw/fabric_config.svh ====
`ifndef FABRIC_CONFIG_SVH
`define FABRIC_CONFIG_SVH

// Bus address layout
`define FAB_APER_WIDTH      17              // Byte address width of the fabric bus
`define FAB_APER_SIZE       10              // Word address bits inside one 4 KB aperture

// Aperture base addresses, byte offsets
`define FAB_REG_BASE        17'h00000
`define FAB_RESERVED_BASE   17'h05000

// Fabric register block, byte offsets inside its window
`define FAB_ID_ADR          12'h000
`define FAB_REV_ADR         12'h004
`define FAB_SCRATCH_ADR     12'h008

`define FAB_DEVICE_ID       32'hABCD0200
`define FAB_REV_LEVEL       32'h00000100
`define FAB_SCRATCH_INIT    32'h12345678

// Undefined offset inside the register window
`define FAB_REG_DEF_VALUE   32'hFAB_DEF_AC

// Nothing mapped at this aperture
`define FAB_BAD_READ_VALUE  32'hBAD_FAB_AC

// Reserved block, byte offsets inside its window
`define RSV_CUST_PROD_ADR   12'h1F8
`define RSV_REVISIONS_ADR   12'h1FC

`define RSV_CUSTOMER_ID     8'h01
`define RSV_PRODUCT_ID      8'h00
`define RSV_MAJOR_REV       16'h0001
`define RSV_MINOR_REV       16'h0000

`define RSV_DEF_VALUE       32'hDEF_FAB_AC

// Bus timeout responder
`define BUS_TIMEOUT_WIDTH   3
`define BUS_TIMEOUT_CYCLES  7               // Stalled cycles before the forced ack

`endif

// ==== hw/fabric_pkg.sv ====
`include "fabric_config.svh"

package fabric_pkg;

    // Data bus width of every target
    localparam int DATA_W = 32;

    // One bus request as driven by the master
    typedef struct packed {
        logic [`FAB_APER_WIDTH-1:0] adr;        // Byte address
        logic                       cyc;        // Cycle active
        logic                       stb;        // Transfer strobe
        logic                       we;         // Write enable
        logic                       rd;         // Read enable
        logic [DATA_W/8-1:0]        byte_stb;   // Byte lanes to write
        logic [DATA_W-1:0]          wr_dat;
    } bus_req_t;

    // Answer of one target, also used for the combined answer
    typedef struct packed {
        logic [DATA_W-1:0] rd_dat;
        logic              ack;                 // One-cycle pulse
    } bus_rsp_t;

    // Per-target chip selects
    typedef struct packed {
        logic fab_reg;      // Fabric register block
        logic reserved;     // Reserved block
    } target_sel_t;

endpackage

// ==== hw/ref_clk_div12.sv ====
module ref_clk_div12 (
    input  logic bitclk_local,
    input  logic RST_IP_i,
    output logic ref_clk_o
);

    localparam logic [3:0] CNT_LAST = 4'd11;
    localparam logic [3:0] CNT_HALF = 4'd5;

    logic [3:0] div_cnt;

    // 0 1 2 3 4 5 6 7 8 9 A B  count
    // 0 0 0 0 0 0 1 1 1 1 1 1  output
    always_ff @(posedge bitclk_local or posedge RST_IP_i) begin
        if (RST_IP_i) begin
            div_cnt   <= 4'd0;
            ref_clk_o <= 1'b0;
        end else begin
            if (div_cnt == CNT_LAST) begin
                div_cnt <= 4'd0;    // Wrap after 12 states
            end else begin
                div_cnt <= div_cnt + 4'd1;
            end

            if (div_cnt == CNT_HALF || div_cnt == CNT_LAST) begin
                ref_clk_o <= ~ref_clk_o;
            end
        end
    end

    a_cnt_range: assert property (
        @(posedge bitclk_local) disable iff (RST_IP_i)
        div_cnt <= CNT_LAST
    ) else $error("ref_clk_div12: count left the 0..11 range");

endmodule

// ==== hw/bus_aperture_decode.sv ====
`include "fabric_config.svh"

module bus_aperture_decode (
    input  fabric_pkg::bus_req_t    bus_req_i,
    input  fabric_pkg::bus_rsp_t    fab_rsp_i,
    input  fabric_pkg::bus_rsp_t    rsv_rsp_i,
    output fabric_pkg::target_sel_t sel_o,
    output fabric_pkg::bus_rsp_t    bus_rsp_o
);

    import fabric_pkg::*;

    // Aperture field is address bits 16:12
    localparam int AP_MSB = `FAB_APER_WIDTH - 1;
    localparam int AP_LSB = `FAB_APER_SIZE + 2;

    localparam logic [`FAB_APER_WIDTH-1:0] REG_BASE = `FAB_REG_BASE;
    localparam logic [`FAB_APER_WIDTH-1:0] RSV_BASE = `FAB_RESERVED_BASE;

    logic [AP_MSB:AP_LSB] aperture;
    logic [DATA_W-1:0]    rd_dat_mux;
    logic                 ack_any;

    assign aperture = bus_req_i.adr[AP_MSB:AP_LSB];

    // Chip selects
    assign sel_o.fab_reg  = bus_req_i.cyc && (aperture == REG_BASE[AP_MSB:AP_LSB]);
    assign sel_o.reserved = bus_req_i.cyc && (aperture == RSV_BASE[AP_MSB:AP_LSB]);

    // Timeout ack also arrives through the reserved block
    assign ack_any = fab_rsp_i.ack | rsv_rsp_i.ack;

    always_comb begin
        case (aperture)
            REG_BASE[AP_MSB:AP_LSB]: rd_dat_mux = fab_rsp_i.rd_dat;
            RSV_BASE[AP_MSB:AP_LSB]: rd_dat_mux = rsv_rsp_i.rd_dat;
            default:                 rd_dat_mux = `FAB_BAD_READ_VALUE;    // Unmapped aperture
        endcase

        // OR of the acks only works with one answer per cycle
        a_ack_exclusive: assert final (!(fab_rsp_i.ack && rsv_rsp_i.ack))
            else $error("bus_aperture_decode: both targets acknowledged");
    end

    assign bus_rsp_o = '{rd_dat: rd_dat_mux, ack: ack_any};

endmodule

// ==== hw/fabric_id_regs.sv ====
`include "fabric_config.svh"

module fabric_id_regs (
    input  logic                 bitclk_local,
    input  logic                 RST_IP_i,
    input  fabric_pkg::bus_req_t bus_req_i,
    input  logic                 sel_i,
    output fabric_pkg::bus_rsp_t rsp_o
);

    import fabric_pkg::*;

    // Word address bits 11:2 inside the window
    localparam int WA_MSB = `FAB_APER_SIZE + 1;

    localparam logic [WA_MSB:0] ID_OFF      = `FAB_ID_ADR;
    localparam logic [WA_MSB:0] REV_OFF     = `FAB_REV_ADR;
    localparam logic [WA_MSB:0] SCRATCH_OFF = `FAB_SCRATCH_ADR;

    logic [WA_MSB:2]   word_adr;
    logic              access;
    logic              scratch_wr;
    logic              ack_q;
    logic [DATA_W-1:0] scratch_q;
    logic [DATA_W-1:0] rd_dat;

    assign word_adr = bus_req_i.adr[WA_MSB:2];

    // New transfer seen, not yet acknowledged
    assign access     = sel_i && bus_req_i.stb && !ack_q;
    assign scratch_wr = access && bus_req_i.we && (word_adr == SCRATCH_OFF[WA_MSB:2]);

    always_ff @(posedge bitclk_local or posedge RST_IP_i) begin
        if (RST_IP_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;    // One cycle after stb
        end
    end

    // Scratch register, byte writable
    always_ff @(posedge bitclk_local or posedge RST_IP_i) begin
        if (RST_IP_i) begin
            scratch_q <= `FAB_SCRATCH_INIT;
        end else if (scratch_wr) begin
            for (int b = 0; b < DATA_W/8; b++) begin
                if (bus_req_i.byte_stb[b]) begin
                    scratch_q[b*8 +: 8] <= bus_req_i.wr_dat[b*8 +: 8];
                end
            end
        end
    end

    // ID and revision are read only
    always_comb begin
        case (word_adr)
            ID_OFF[WA_MSB:2]:      rd_dat = `FAB_DEVICE_ID;
            REV_OFF[WA_MSB:2]:     rd_dat = `FAB_REV_LEVEL;
            SCRATCH_OFF[WA_MSB:2]: rd_dat = scratch_q;
            default:               rd_dat = `FAB_REG_DEF_VALUE;
        endcase
    end

    assign rsp_o = '{rd_dat: rd_dat, ack: ack_q};

    // Read data in the ack cycle needs the request still on the bus
    a_ack_held_req: assert property (
        @(posedge bitclk_local) disable iff (RST_IP_i)
        rsp_o.ack |-> (sel_i && bus_req_i.stb)
    ) else $error("fabric_id_regs: ack for a request no longer on the bus");

endmodule

// ==== hw/reserved_id_regs.sv ====
`include "fabric_config.svh"

module reserved_id_regs (
    input  logic                 bitclk_local,
    input  logic                 RST_IP_i,
    input  fabric_pkg::bus_req_t bus_req_i,
    input  logic                 sel_i,
    input  logic                 bus_ack_i,
    output fabric_pkg::bus_rsp_t rsp_o
);

    import fabric_pkg::*;

    localparam int WA_MSB = `FAB_APER_SIZE + 1;

    localparam logic [WA_MSB:0] CUST_PROD_OFF = `RSV_CUST_PROD_ADR;
    localparam logic [WA_MSB:0] REVISIONS_OFF = `RSV_REVISIONS_ADR;

    localparam logic [`BUS_TIMEOUT_WIDTH-1:0] TO_LIMIT = `BUS_TIMEOUT_CYCLES;

    // Fixed ID words
    localparam logic [DATA_W-1:0] CUST_PROD_WORD =
        {16'h0000, `RSV_CUSTOMER_ID, `RSV_PRODUCT_ID};
    localparam logic [DATA_W-1:0] REVISIONS_WORD =
        {`RSV_MAJOR_REV, `RSV_MINOR_REV};

    logic [WA_MSB:2]                word_adr;
    logic                           bus_busy;
    logic                           reg_ack_q;
    logic                           to_ack_q;
    logic [`BUS_TIMEOUT_WIDTH-1:0]  to_cnt;
    logic [DATA_W-1:0]              rd_dat;

    assign word_adr = bus_req_i.adr[WA_MSB:2];
    assign bus_busy = bus_req_i.cyc && bus_req_i.stb;   // Any target, any aperture

    // Register ack, one cycle after stb
    always_ff @(posedge bitclk_local or posedge RST_IP_i) begin
        if (RST_IP_i) begin
            reg_ack_q <= 1'b0;
        end else begin
            reg_ack_q <= sel_i && bus_req_i.stb && !reg_ack_q;
        end
    end

    always_comb begin
        case (word_adr)
            CUST_PROD_OFF[WA_MSB:2]: rd_dat = CUST_PROD_WORD;
            REVISIONS_OFF[WA_MSB:2]: rd_dat = REVISIONS_WORD;
            default:                 rd_dat = `RSV_DEF_VALUE;
        endcase
    end

    // Timeout responder
    // Counts stalled cycles of the whole bus, forces an ack on the 8th
    always_ff @(posedge bitclk_local or posedge RST_IP_i) begin
        if (RST_IP_i) begin
            to_cnt   <= '0;
            to_ack_q <= 1'b0;
        end else begin
            to_ack_q <= 1'b0;
            if (!bus_busy || bus_ack_i) begin
                to_cnt <= '0;                   // Idle or answered
            end else if (to_cnt == TO_LIMIT) begin
                to_cnt   <= '0;
                to_ack_q <= 1'b1;
            end else begin
                to_cnt <= to_cnt + 1'b1;
            end
        end
    end

    assign rsp_o = '{rd_dat: rd_dat, ack: reg_ack_q | to_ack_q};

    // A mapped reserved access is answered long before the timeout
    a_ack_exclusive: assert property (
        @(posedge bitclk_local) disable iff (RST_IP_i)
        !(reg_ack_q && to_ack_q)
    ) else $error("reserved_id_regs: timeout ack with register ack");

endmodule

// ==== hw/fabric_bus_top.sv ====
module fabric_bus_top (
    input  logic                 bitclk_local,
    input  logic                 RST_IP_i,
    input  fabric_pkg::bus_req_t bus_req_i,
    output fabric_pkg::bus_rsp_t bus_rsp_o,
    output logic                 ref_clk_o
);

    import fabric_pkg::*;

    target_sel_t target_sel;
    bus_rsp_t    fab_rsp;
    bus_rsp_t    rsv_rsp;

    // Selects, ack combine, read mux
    bus_aperture_decode u_decode (
        .bus_req_i (bus_req_i),
        .fab_rsp_i (fab_rsp),
        .rsv_rsp_i (rsv_rsp),
        .sel_o     (target_sel),
        .bus_rsp_o (bus_rsp_o)
    );

    fabric_id_regs u_fabric_regs (
        .bitclk_local (bitclk_local),
        .RST_IP_i     (RST_IP_i),
        .bus_req_i    (bus_req_i),
        .sel_i        (target_sel.fab_reg),
        .rsp_o        (fab_rsp)
    );

    // Also answers unmapped apertures
    reserved_id_regs u_reserved_regs (
        .bitclk_local (bitclk_local),
        .RST_IP_i     (RST_IP_i),
        .bus_req_i    (bus_req_i),
        .sel_i        (target_sel.reserved),
        .bus_ack_i    (bus_rsp_o.ack),      // Combined ack
        .rsp_o        (rsv_rsp)
    );

    ref_clk_div12 u_ref_clk_div (
        .bitclk_local (bitclk_local),
        .RST_IP_i     (RST_IP_i),
        .ref_clk_o    (ref_clk_o)
    );

endmodule

// ==== bench/fabric_bus_checker.sv ====
module fabric_bus_checker #(
    parameter int NAME_CHARS       = 12,
    parameter int REF_CHECK_CYCLES = 48     // Four full reference periods
) (
    input  logic                             bitclk_local,
    input  logic                             RST_IP_i,
    input  fabric_pkg::bus_req_t             bus_req_i,
    input  fabric_pkg::bus_rsp_t             bus_rsp_i,
    input  logic                             ref_clk_i,
    input  logic [8*NAME_CHARS-1:0]          exp_name_i,
    input  int                               exp_idx_i,
    input  logic                             exp_read_i,
    input  logic [fabric_pkg::DATA_W-1:0]    exp_dat_i,
    input  int                               exp_lat_i,
    output int                               pass_cnt_o,
    output int                               fail_cnt_o,
    output logic                             ref_done_o
);

    import fabric_pkg::*;

    logic in_xfer;      // Transfer started, ack not yet seen
    int   lat_cnt;
    int   since_rst;    // Edges since reset release
    logic ref_exp;
    logic ref_ok;

    initial begin
        pass_cnt_o = 0;
        fail_cnt_o = 0;
        ref_done_o = 1'b0;
        in_xfer    = 1'b0;
        lat_cnt    = 0;
        since_rst  = 0;
        ref_ok     = 1'b1;
    end

    task automatic compare_xfer();
        logic ok;
        ok = 1'b1;
        if (lat_cnt != exp_lat_i) begin
            $display("t=%0t test %0d: ack came %0d cycles after stb, expected %0d",
                     $time, exp_idx_i, lat_cnt, exp_lat_i);
            ok = 1'b0;
        end
        if (exp_read_i && (bus_rsp_i.rd_dat !== exp_dat_i)) begin
            $display("ERR t=%0t bus_rsp_o.rd_dat exp=%h got=%h",
                     $time, exp_dat_i, bus_rsp_i.rd_dat);
            ok = 1'b0;
        end
        if (ok) begin
            pass_cnt_o = pass_cnt_o + 1;
            $display("test %0d %0s: ok", exp_idx_i, exp_name_i);
        end else begin
            fail_cnt_o = fail_cnt_o + 1;
            $display("test %0d %0s: failed", exp_idx_i, exp_name_i);
        end
    endtask

    // Values sampled here are the ones settled before the edge
    always @(posedge bitclk_local) begin
        if (RST_IP_i) begin
            in_xfer   = 1'b0;
            since_rst = 0;
        end else begin
            if (!ref_done_o) begin
                since_rst = since_rst + 1;
                ref_exp   = (((since_rst - 1) % 12) >= 6);   // Six low, then six high
                if (ref_clk_i !== ref_exp) begin
                    $display("ERR t=%0t ref_clk_o exp=%b got=%b", $time, ref_exp, ref_clk_i);
                    ref_ok = 1'b0;
                end
                if (since_rst == REF_CHECK_CYCLES) begin
                    ref_done_o = 1'b1;
                    if (ref_ok) begin
                        pass_cnt_o = pass_cnt_o + 1;
                        $display("test ref_clk_div12: ok");
                    end else begin
                        fail_cnt_o = fail_cnt_o + 1;
                        $display("test ref_clk_div12: failed");
                    end
                end
            end

            if (in_xfer) begin
                lat_cnt = lat_cnt + 1;
            end
            if (bus_rsp_i.ack) begin
                if (!in_xfer) begin
                    $display("t=%0t ack seen with no transfer in progress", $time);
                    fail_cnt_o = fail_cnt_o + 1;
                end else begin
                    compare_xfer();
                    in_xfer = 1'b0;
                end
            end else if (in_xfer && !bus_req_i.stb) begin
                in_xfer = 1'b0;     // Master gave up
            end

            if (!in_xfer && bus_req_i.cyc && bus_req_i.stb && !bus_rsp_i.ack) begin
                in_xfer = 1'b1;
                lat_cnt = 0;
            end
        end
    end

endmodule

// ==== bench/fabric_bus_tb.sv ====
module fabric_bus_tb;

    import fabric_pkg::*;

    localparam int          CLK_PERIOD      = 40;
    localparam int          NAME_CHARS      = 12;
    localparam int          NUM_TESTS       = 15;
    localparam int          ACK_LIMIT       = 16;   // Cycles before a transfer is given up
    localparam int          WATCHDOG_CYCLES = NUM_TESTS * 20 + 200;
    localparam int unsigned SEED            = 32'h68e3;

    // One table row per bus transfer
    typedef struct packed {
        logic [8*NAME_CHARS-1:0] name;
        logic                    we;
        logic [16:0]             adr;
        logic [DATA_W-1:0]       wr_dat;
        logic [3:0]              byte_stb;
        logic [DATA_W-1:0]       exp_dat;
    } test_row_t;

    logic      bitclk_local;
    logic      RST_IP_i;
    bus_req_t  bus_req;
    bus_rsp_t  bus_rsp;
    logic      ref_clk;

    test_row_t rows [NUM_TESTS];
    int        n_rows;
    int        no_ack_cnt;

    logic [8*NAME_CHARS-1:0] exp_name;
    int                      exp_idx;
    logic                    exp_read;
    logic [DATA_W-1:0]       exp_dat;
    int                      exp_lat;
    int                      chk_pass;
    int                      chk_fail;
    logic                    ref_done;

    fabric_bus_top u_dut (
        .bitclk_local (bitclk_local),
        .RST_IP_i     (RST_IP_i),
        .bus_req_i    (bus_req),
        .bus_rsp_o    (bus_rsp),
        .ref_clk_o    (ref_clk)
    );

    fabric_bus_checker #(.NAME_CHARS(NAME_CHARS)) u_chk (
        .bitclk_local (bitclk_local),
        .RST_IP_i     (RST_IP_i),
        .bus_req_i    (bus_req),
        .bus_rsp_i    (bus_rsp),
        .ref_clk_i    (ref_clk),
        .exp_name_i   (exp_name),
        .exp_idx_i    (exp_idx),
        .exp_read_i   (exp_read),
        .exp_dat_i    (exp_dat),
        .exp_lat_i    (exp_lat),
        .pass_cnt_o   (chk_pass),
        .fail_cnt_o   (chk_fail),
        .ref_done_o   (ref_done)
    );

    initial begin
        bitclk_local = 1'b0;
        forever #(CLK_PERIOD/2) bitclk_local = ~bitclk_local;
    end

    // Mapped apertures 0 and 5 answer after one cycle, the rest hit the timeout
    function automatic int ack_latency(input logic [16:0] adr);
        if (adr[16:12] == 5'h00 || adr[16:12] == 5'h05) begin
            return 1;
        end
        return 8;
    endfunction

    task automatic add_row(input logic [8*NAME_CHARS-1:0] name, input logic we,
                           input logic [16:0] adr, input logic [DATA_W-1:0] wr_dat,
                           input logic [3:0] byte_stb, input logic [DATA_W-1:0] exp_dat);
        rows[n_rows].name     = name;
        rows[n_rows].we       = we;
        rows[n_rows].adr      = adr;
        rows[n_rows].wr_dat   = wr_dat;
        rows[n_rows].byte_stb = byte_stb;
        rows[n_rows].exp_dat  = exp_dat;
        n_rows = n_rows + 1;
    endtask

    task automatic load_table();
        //      name          we    adr        wr_dat        stb    expected
        add_row("rd_id",      1'b0, 17'h00000, 32'h0,        4'h0, 32'hABCD0200);
        add_row("rd_rev",     1'b0, 17'h00004, 32'h0,        4'h0, 32'h00000100);
        add_row("rd_scr_rst", 1'b0, 17'h00008, 32'h0,        4'h0, 32'h12345678);
        add_row("wr_scr",     1'b1, 17'h00008, 32'hAABBCCDD, 4'h5, 32'h0);
        add_row("rd_scr",     1'b0, 17'h00008, 32'h0,        4'h0, 32'h12BB56DD);
        add_row("wr_id",      1'b1, 17'h00000, 32'hFFFFFFFF, 4'hF, 32'h0);
        add_row("rd_id_again",1'b0, 17'h00000, 32'h0,        4'h0, 32'hABCD0200);
        add_row("rd_cust",    1'b0, 17'h051F8, 32'h0,        4'h0, 32'h00000100);
        add_row("rd_revs",    1'b0, 17'h051FC, 32'h0,        4'h0, 32'h00010000);
        add_row("rd_rsv_def", 1'b0, 17'h05010, 32'h0,        4'h0, 32'hDEF_FAB_AC);
        add_row("rd_reg_def", 1'b0, 17'h00010, 32'h0,        4'h0, 32'hFAB_DEF_AC);
        add_row("rd_unmap1",  1'b0, 17'h01000, 32'h0,        4'h0, 32'hBAD_FAB_AC);
        add_row("rd_unmap3",  1'b0, 17'h03000, 32'h0,        4'h0, 32'hBAD_FAB_AC);
        add_row("wr_unmap2",  1'b1, 17'h02008, 32'h00000000, 4'hF, 32'h0);
        add_row("rd_scr_last",1'b0, 17'h00008, 32'h0,        4'h0, 32'h12BB56DD);
    endtask

    // Holds the request until ack, then drops cyc and stb
    task automatic run_row(input int idx);
        bus_req_t req;
        int       waited;
        logic     acked;
        req          = '0;
        req.adr      = rows[idx].adr;
        req.cyc      = 1'b1;
        req.stb      = 1'b1;
        req.we       = rows[idx].we;
        req.rd       = !rows[idx].we;
        req.byte_stb = rows[idx].byte_stb;
        req.wr_dat   = rows[idx].wr_dat;
        exp_name <= rows[idx].name;
        exp_idx  <= idx;
        exp_read <= !rows[idx].we;
        exp_dat  <= rows[idx].exp_dat;
        exp_lat  <= ack_latency(rows[idx].adr);
        bus_req  <= req;
        waited = 0;
        acked  = 1'b0;
        while (!acked && waited < ACK_LIMIT) begin
            @(posedge bitclk_local);
            waited = waited + 1;
            acked  = bus_rsp.ack;
        end
        bus_req <= '0;
        if (!acked) begin
            $display("test %0d %0s: failed, no ack within %0d cycles",
                     idx, rows[idx].name, ACK_LIMIT);
            no_ack_cnt = no_ack_cnt + 1;
        end
    endtask

    initial begin
        int unsigned seed_val;
        int unsigned rnd;
        int          gap;
        bus_req    = '0;
        RST_IP_i   = 1'b1;
        exp_name   = '0;
        exp_idx    = 0;
        exp_read   = 1'b0;
        exp_dat    = '0;
        exp_lat    = 0;
        n_rows     = 0;
        no_ack_cnt = 0;
        seed_val   = SEED;
        rnd        = $urandom(seed_val);
        load_table();

        repeat (3) @(posedge bitclk_local);
        RST_IP_i <= 1'b0;

        for (int i = 0; i < n_rows; i++) begin
            gap = $urandom % 4 + 1;         // Idle gap of 1 to 4 cycles
            repeat (gap) @(posedge bitclk_local);
            run_row(i);
        end

        while (!ref_done) begin
            @(posedge bitclk_local);
        end
        @(posedge bitclk_local);

        $display("tests: %0d passed, %0d failed", chk_pass, chk_fail + no_ack_cnt);
        if (chk_fail + no_ack_cnt == 0 && chk_pass == n_rows + 1) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+hw
hw/fabric_pkg.sv
hw/ref_clk_div12.sv
hw/bus_aperture_decode.sv
hw/fabric_id_regs.sv
hw/reserved_id_regs.sv
hw/fabric_bus_top.sv
bench/fabric_bus_checker.sv
bench/fabric_bus_tb.sv
